// File: source/aluPkg.sv
package aluPkg;

    // datapath geometry
    localparam int DATA_WIDTH = 32;
    localparam int CHUNK_WIDTH = 8;
    localparam int NUM_CHUNKS = DATA_WIDTH / CHUNK_WIDTH;
    localparam int CHUNK_INDEX_WIDTH = 2;

    // command encoding, one code per operation
    localparam int CMD_WIDTH = 3;
    localparam int NUM_COMMANDS = 8;

    localparam logic [CMD_WIDTH-1:0] CMD_ADD = 3'd0;
    localparam logic [CMD_WIDTH-1:0] CMD_SUB = 3'd1;
    localparam logic [CMD_WIDTH-1:0] CMD_XOR = 3'd2;
    localparam logic [CMD_WIDTH-1:0] CMD_SLT = 3'd3;
    localparam logic [CMD_WIDTH-1:0] CMD_AND = 3'd4;
    localparam logic [CMD_WIDTH-1:0] CMD_NAND = 3'd5;
    localparam logic [CMD_WIDTH-1:0] CMD_NOR = 3'd6;
    localparam logic [CMD_WIDTH-1:0] CMD_OR = 3'd7;

    // sequencer state encoding
    localparam int SEQ_STATE_WIDTH = 2;

    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_IDLE = 2'd0;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_RUN = 2'd1;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_FINISH = 2'd2;

endpackage

// File: source/busPkg.sv
package busPkg;

    localparam int ADDR_WIDTH = 5;
    localparam int RESP_WIDTH = 2;

    // register map
    localparam logic [ADDR_WIDTH-1:0] ADDR_OPERAND_A = 5'h00;
    localparam logic [ADDR_WIDTH-1:0] ADDR_OPERAND_B = 5'h04;
    localparam logic [ADDR_WIDTH-1:0] ADDR_COMMAND = 5'h08;
    localparam logic [ADDR_WIDTH-1:0] ADDR_RESULT = 5'h0C;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 5'h10;

    // bit positions inside the status word
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_CARRY = 1;
    localparam int STATUS_ZERO = 2;
    localparam int STATUS_OVERFLOW = 3;

    // AXI response codes
    localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;
    localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage

// File: source/aluSlice.sv
`timescale 1ns/100ps

module aluSlice import aluPkg::*; (
    input  logic [CHUNK_WIDTH-1:0] operandA,
    input  logic [CHUNK_WIDTH-1:0] operandB,
    input  logic [CMD_WIDTH-1:0]   command,
    input  logic                   carryIn,
    output logic [CHUNK_WIDTH-1:0] result,
    output logic                   carryOut
);

    logic [NUM_COMMANDS-1:0] cmdSelect;
    logic [CHUNK_WIDTH:0]    carryBus;
    logic                    invertB;
    logic                    arithSelect;

    // one-hot operation select, one line per command
    assign cmdSelect = NUM_COMMANDS'(1) << command;

    // subtract and set-less-than both run the adder as a - b
    assign invertB = cmdSelect[CMD_SUB] | cmdSelect[CMD_SLT];
    assign arithSelect = cmdSelect[CMD_ADD] | cmdSelect[CMD_SUB] | cmdSelect[CMD_SLT];

    assign carryBus[0] = carryIn;
    assign carryOut = carryBus[CHUNK_WIDTH];

    for (genvar i = 0; i < CHUNK_WIDTH; i++) begin : bitSlices
        logic bEff;
        logic sum;
        logic andBit;
        logic orBit;
        logic xorBit;

        assign bEff = operandB[i] ^ invertB;
        assign sum = operandA[i] ^ bEff ^ carryBus[i];
        assign carryBus[i+1] = (operandA[i] & bEff) | (carryBus[i] & (operandA[i] ^ bEff));

        assign andBit = operandA[i] & operandB[i];
        assign orBit = operandA[i] | operandB[i];
        assign xorBit = operandA[i] ^ operandB[i];

        // only one select line is high, so the terms can simply be ORed
        assign result[i] = (arithSelect & sum)
                         | (cmdSelect[CMD_XOR] & xorBit)
                         | (cmdSelect[CMD_AND] & andBit)
                         | (cmdSelect[CMD_NAND] & ~andBit)
                         | (cmdSelect[CMD_NOR] & ~orBit)
                         | (cmdSelect[CMD_OR] & orBit);
    end

endmodule

// File: source/chunkCounter.sv
`timescale 1ns/100ps

module chunkCounter import aluPkg::*; (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         clear,
    input  logic                         enable,
    output logic [CHUNK_INDEX_WIDTH-1:0] chunkIndex,
    output logic                         lastChunk
);

    // clear wins over enable so a new operation always starts at chunk 0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            chunkIndex <= '0;
        end else if (clear) begin
            chunkIndex <= '0;
        end else if (enable) begin
            chunkIndex <= chunkIndex + 1'b1;
        end
    end

    assign lastChunk = (chunkIndex == CHUNK_INDEX_WIDTH'(NUM_CHUNKS - 1));

endmodule

// File: source/aluSequencer.sv
`timescale 1ns/100ps

module aluSequencer import aluPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic lastChunk,
    output logic counterClear,
    output logic counterEnable,
    output logic opStart,
    output logic chunkValid,
    output logic done,
    output logic busy
);

    logic [SEQ_STATE_WIDTH-1:0] state;
    logic [SEQ_STATE_WIDTH-1:0] nextState;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= SEQ_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    nextState = SEQ_RUN;
                end
            end
            SEQ_RUN: begin
                // one cycle per chunk, leave after the top chunk
                if (lastChunk) begin
                    nextState = SEQ_FINISH;
                end
            end
            SEQ_FINISH: nextState = SEQ_IDLE;
            default:    nextState = SEQ_IDLE;
        endcase
    end

    // start is only honoured from idle
    assign opStart = start & (state == SEQ_IDLE);
    assign counterClear = opStart;

    assign counterEnable = (state == SEQ_RUN);
    assign chunkValid = (state == SEQ_RUN);
    assign done = (state == SEQ_FINISH);
    assign busy = (state != SEQ_IDLE);

endmodule

// File: source/resultAssembler.sv
`timescale 1ns/100ps

module resultAssembler import aluPkg::*; (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         opStart,
    input  logic                         chunkValid,
    input  logic                         finish,
    input  logic [CHUNK_INDEX_WIDTH-1:0] chunkIndex,
    input  logic [CMD_WIDTH-1:0]         command,
    input  logic                         operandSignA,
    input  logic                         operandSignB,
    input  logic [CHUNK_WIDTH-1:0]       sliceResult,
    input  logic                         sliceCarry,
    output logic                         carryToSlice,
    output logic [DATA_WIDTH-1:0]        result,
    output logic                         carry,
    output logic                         zero,
    output logic                         overflow
);

    logic [DATA_WIDTH-1:0] chunkData;
    logic                  carryReg;
    logic                  isAdd;
    logic                  isSub;
    logic                  isSlt;
    logic                  resultSign;
    logic                  addOverflow;
    logic                  subOverflow;
    logic                  sltBit;

    assign isAdd = (command == CMD_ADD);
    assign isSub = (command == CMD_SUB);
    assign isSlt = (command == CMD_SLT);

    // ripple carry held across chunks, seeded with 1 for a - b
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carryReg <= 1'b0;
        end else if (opStart) begin
            carryReg <= isSub | isSlt;
        end else if (chunkValid) begin
            carryReg <= sliceCarry;
        end
    end

    always_ff @(posedge clk) begin
        if (chunkValid) begin
            chunkData[chunkIndex*CHUNK_WIDTH +: CHUNK_WIDTH] <= sliceResult;
        end
    end

    assign carryToSlice = carryReg;

    // top bit of the top chunk is the sign of the sum or difference
    assign resultSign = chunkData[DATA_WIDTH-1];

    assign addOverflow = (operandSignA == operandSignB) & (resultSign != operandSignA);
    assign subOverflow = (operandSignA != operandSignB) & (resultSign != operandSignA);

    // SLT: sign of a - b corrected by its overflow
    assign sltBit = resultSign ^ subOverflow;

    assign result = isSlt ? DATA_WIDTH'(sltBit) : chunkData;

    // flags only mean something once all chunks are in
    assign carry = finish & (isAdd | isSub | isSlt) & carryReg;
    assign overflow = finish & ((isAdd & addOverflow) | (isSub & subOverflow));
    assign zero = finish & (result == '0);

endmodule

// File: source/aluRegs.sv
`timescale 1ns/100ps

module aluRegs import aluPkg::*, busPkg::*; (
    input  logic                         clk,
    input  logic                         arstN,
    // AXI4-Lite slave
    input  logic                         awValid,
    output logic                         awReady,
    input  logic [ADDR_WIDTH-1:0]        awAddr,
    input  logic                         wValid,
    output logic                         wReady,
    input  logic [DATA_WIDTH-1:0]        wData,
    output logic                         bValid,
    input  logic                         bReady,
    output logic [RESP_WIDTH-1:0]        bResp,
    input  logic                         arValid,
    output logic                         arReady,
    input  logic [ADDR_WIDTH-1:0]        arAddr,
    output logic                         rValid,
    input  logic                         rReady,
    output logic [DATA_WIDTH-1:0]        rData,
    output logic [RESP_WIDTH-1:0]        rResp,
    // sequencer and datapath side
    output logic                         start,
    input  logic                         busy,
    input  logic                         done,
    input  logic [CHUNK_INDEX_WIDTH-1:0] chunkIndex,
    output logic [CHUNK_WIDTH-1:0]       operandAChunk,
    output logic [CHUNK_WIDTH-1:0]       operandBChunk,
    output logic                         operandSignA,
    output logic                         operandSignB,
    output logic [CMD_WIDTH-1:0]         command,
    input  logic [DATA_WIDTH-1:0]        result,
    input  logic                         carry,
    input  logic                         zero,
    input  logic                         overflow
);

    logic [DATA_WIDTH-1:0] operandA;
    logic [DATA_WIDTH-1:0] operandB;
    logic [CMD_WIDTH-1:0]  commandReg;
    logic [DATA_WIDTH-1:0] resultReg;
    logic                  carryFlag;
    logic                  zeroFlag;
    logic                  overflowFlag;
    logic [DATA_WIDTH-1:0] statusWord;
    logic                  writeAccept;
    logic                  readAccept;
    logic [DATA_WIDTH-1:0] readData;
    logic [RESP_WIDTH-1:0] readResp;
    logic [RESP_WIDTH-1:0] writeResp;

    // address and data are taken together in one handshake
    assign writeAccept = awReady & awValid & wValid;
    assign readAccept = arReady & arValid;
    assign arReady = ~rValid;

    assign start = writeAccept & (awAddr == ADDR_COMMAND) & ~busy;

    always_comb begin
        case (awAddr)
            ADDR_OPERAND_A: writeResp = RESP_OKAY;
            ADDR_OPERAND_B: writeResp = RESP_OKAY;
            ADDR_COMMAND:   writeResp = busy ? RESP_SLVERR : RESP_OKAY;
            default:        writeResp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awReady <= 1'b0;
            wReady <= 1'b0;
            bValid <= 1'b0;
        end else begin
            awReady <= awValid & wValid & ~awReady & ~bValid;
            wReady <= awValid & wValid & ~awReady & ~bValid;
            if (writeAccept) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            bResp <= writeResp;
            if (awAddr == ADDR_OPERAND_A) begin
                operandA <= wData;
            end
            if (awAddr == ADDR_OPERAND_B) begin
                operandB <= wData;
            end
        end
        if (start) begin
            commandReg <= wData[CMD_WIDTH-1:0];
        end
    end

    // the new command is passed straight through in the start cycle
    assign command = start ? wData[CMD_WIDTH-1:0] : commandReg;

    assign operandAChunk = operandA[chunkIndex*CHUNK_WIDTH +: CHUNK_WIDTH];
    assign operandBChunk = operandB[chunkIndex*CHUNK_WIDTH +: CHUNK_WIDTH];
    assign operandSignA = operandA[DATA_WIDTH-1];
    assign operandSignB = operandB[DATA_WIDTH-1];

    // results are captured in the finish cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultReg <= '0;
            carryFlag <= 1'b0;
            zeroFlag <= 1'b0;
            overflowFlag <= 1'b0;
        end else if (done) begin
            resultReg <= result;
            carryFlag <= carry;
            zeroFlag <= zero;
            overflowFlag <= overflow;
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[STATUS_BUSY] = busy;
        statusWord[STATUS_CARRY] = carryFlag;
        statusWord[STATUS_ZERO] = zeroFlag;
        statusWord[STATUS_OVERFLOW] = overflowFlag;
    end

    always_comb begin
        readData = '0;
        readResp = RESP_OKAY;
        case (arAddr)
            ADDR_OPERAND_A: readData = operandA;
            ADDR_OPERAND_B: readData = operandB;
            ADDR_COMMAND:   readData = DATA_WIDTH'(commandReg);
            ADDR_RESULT:    readData = resultReg;
            ADDR_STATUS:    readData = statusWord;
            default:        readResp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rValid <= 1'b0;
        end else if (readAccept) begin
            rValid <= 1'b1;
        end else if (rReady) begin
            rValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (readAccept) begin
            rData <= readData;
            rResp <= readResp;
        end
    end

endmodule

// File: source/aluTop.sv
`timescale 1ns/100ps

module aluTop import aluPkg::*, busPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  awValid,
    output logic                  awReady,
    input  logic [ADDR_WIDTH-1:0] awAddr,
    input  logic                  wValid,
    output logic                  wReady,
    input  logic [DATA_WIDTH-1:0] wData,
    output logic                  bValid,
    input  logic                  bReady,
    output logic [RESP_WIDTH-1:0] bResp,
    input  logic                  arValid,
    output logic                  arReady,
    input  logic [ADDR_WIDTH-1:0] arAddr,
    output logic                  rValid,
    input  logic                  rReady,
    output logic [DATA_WIDTH-1:0] rData,
    output logic [RESP_WIDTH-1:0] rResp
);

    logic                         start;
    logic                         busy;
    logic                         done;
    logic                         opStart;
    logic                         chunkValid;
    logic                         counterClear;
    logic                         counterEnable;
    logic                         lastChunk;
    logic [CHUNK_INDEX_WIDTH-1:0] chunkIndex;
    logic [CHUNK_WIDTH-1:0]       operandAChunk;
    logic [CHUNK_WIDTH-1:0]       operandBChunk;
    logic                         operandSignA;
    logic                         operandSignB;
    logic [CMD_WIDTH-1:0]         command;
    logic [CHUNK_WIDTH-1:0]       sliceResult;
    logic                         sliceCarry;
    logic                         carryToSlice;
    logic [DATA_WIDTH-1:0]        result;
    logic                         carry;
    logic                         zero;
    logic                         overflow;

    aluRegs regs (
        .clk, .arstN,
        .awValid, .awReady, .awAddr, .wValid, .wReady, .wData,
        .bValid, .bReady, .bResp,
        .arValid, .arReady, .arAddr, .rValid, .rReady, .rData, .rResp,
        .start, .busy, .done, .chunkIndex,
        .operandAChunk, .operandBChunk, .operandSignA, .operandSignB, .command,
        .result, .carry, .zero, .overflow
    );

    aluSequencer sequencer (
        .clk, .arstN, .start, .lastChunk,
        .counterClear, .counterEnable, .opStart, .chunkValid, .done, .busy
    );

    chunkCounter counter (
        .clk, .arstN,
        .clear(counterClear), .enable(counterEnable), .chunkIndex, .lastChunk
    );

    aluSlice slice (
        .operandA(operandAChunk), .operandB(operandBChunk), .command,
        .carryIn(carryToSlice), .result(sliceResult), .carryOut(sliceCarry)
    );

    // the done cycle is the finish step of the assembler
    resultAssembler assembler (
        .clk, .arstN, .opStart, .chunkValid, .finish(done), .chunkIndex, .command,
        .operandSignA, .operandSignB, .sliceResult, .sliceCarry,
        .carryToSlice, .result, .carry, .zero, .overflow
    );

endmodule

// File: tests/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic arstN
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held for two rising edges, released just after the second one
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

// File: tests/aluTb.sv
`timescale 1ns/100ps

module aluTb import aluPkg::*, busPkg::*; ();

    localparam int CLK_PERIOD_NS = 10;
    localparam int CYCLES_PER_OP = 50;
    localparam int NUM_RANDOM_OPS = 200;
    localparam int NUM_CORNER_VALUES = 4;
    localparam int NUM_CORNER_CMDS = 3;
    localparam int NUM_BUSY_OPS = 3;
    localparam int NUM_STALL_OPS = 30;
    localparam int TOTAL_OPS = 2 + NUM_RANDOM_OPS + NUM_CORNER_VALUES * NUM_CORNER_VALUES
                             * NUM_CORNER_CMDS + NUM_BUSY_OPS + NUM_STALL_OPS;

    logic                  clk;
    logic                  arstN;
    logic                  awValid;
    logic                  awReady;
    logic [ADDR_WIDTH-1:0] awAddr;
    logic                  wValid;
    logic                  wReady;
    logic [DATA_WIDTH-1:0] wData;
    logic                  bValid;
    logic                  bReady;
    logic [RESP_WIDTH-1:0] bResp;
    logic                  arValid;
    logic                  arReady;
    logic [ADDR_WIDTH-1:0] arAddr;
    logic                  rValid;
    logic                  rReady;
    logic [DATA_WIDTH-1:0] rData;
    logic [RESP_WIDTH-1:0] rResp;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     testsPassed;
    int     testsFailed;
    int     maxStall;

    logic [DATA_WIDTH-1:0] cornerValues [NUM_CORNER_VALUES];
    logic [CMD_WIDTH-1:0]  cornerCmds [NUM_CORNER_CMDS];
    logic [ADDR_WIDTH-1:0] badWriteAddrs [5];
    logic [ADDR_WIDTH-1:0] unmappedAddrs [4];

    clockGen clocks (.clk, .arstN);

    aluTop DUT (
        .clk, .arstN,
        .awValid, .awReady, .awAddr, .wValid, .wReady, .wData,
        .bValid, .bReady, .bResp,
        .arValid, .arReady, .arAddr, .rValid, .rReady, .rData, .rResp
    );

    function automatic int randomBelow(int limit);
        logic [31:0] raw;
        raw = $random(seed);
        return int'(raw % 32'(limit));
    endfunction

    function automatic int stallLength();
        if (maxStall == 0) begin
            return 0;
        end
        return randomBelow(maxStall + 1);
    endfunction

    task automatic checkEqual(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // all bus tasks start and end 1 ns after a rising edge
    task automatic writeReg(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data,
                            output logic [RESP_WIDTH-1:0] resp);
        int stall;
        stall = stallLength();
        awAddr = addr;
        wData = data;
        awValid = 1'b1;
        wValid = 1'b1;
        // ready comes a cycle after both valids and the handshake follows on the next edge
        do begin
            @(posedge clk);
            #1;
        end while (!(awReady && wReady));
        @(posedge clk);
        #1;
        awValid = 1'b0;
        wValid = 1'b0;
        resp = bResp;
        checkEqual("bValid", 32'd1, 32'(bValid));
        checkEqual("awReady after handshake", 32'd0, 32'(awReady));
        checkEqual("wReady after handshake", 32'd0, 32'(wReady));
        repeat (stall) begin
            @(posedge clk);
            #1;
            checkEqual("bValid held", 32'd1, 32'(bValid));
            checkEqual("bResp held", 32'(resp), 32'(bResp));
        end
        bReady = 1'b1;
        @(posedge clk);
        #1;
        bReady = 1'b0;
    endtask

    task automatic readReg(input logic [ADDR_WIDTH-1:0] addr,
                           output logic [DATA_WIDTH-1:0] data,
                           output logic [RESP_WIDTH-1:0] resp);
        int stall;
        stall = stallLength();
        arAddr = addr;
        arValid = 1'b1;
        while (!arReady) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        arValid = 1'b0;
        data = rData;
        resp = rResp;
        checkEqual("rValid", 32'd1, 32'(rValid));
        checkEqual("arReady while pending", 32'd0, 32'(arReady));
        repeat (stall) begin
            @(posedge clk);
            #1;
            checkEqual("rValid held", 32'd1, 32'(rValid));
            checkEqual("rData held", data, rData);
            checkEqual("rResp held", 32'(resp), 32'(rResp));
        end
        rReady = 1'b1;
        @(posedge clk);
        #1;
        rReady = 1'b0;
        checkEqual("arReady after response", 32'd1, 32'(arReady));
    endtask

    // reference model where SUB and SLT carry is the carry out of a + ~b + 1
    task automatic modelOperation(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                                  input logic [CMD_WIDTH-1:0] cmd,
                                  output logic [DATA_WIDTH-1:0] res, output logic carry,
                                  output logic zero, output logic overflow);
        logic [DATA_WIDTH:0] wide;
        carry = 1'b0;
        overflow = 1'b0;
        wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
        case (cmd)
            CMD_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                res = wide[DATA_WIDTH-1:0];
                carry = wide[DATA_WIDTH];
                overflow = (a[31] == b[31]) && (res[31] != a[31]);
            end
            CMD_SUB: begin
                res = wide[DATA_WIDTH-1:0];
                carry = wide[DATA_WIDTH];
                overflow = (a[31] != b[31]) && (res[31] != a[31]);
            end
            CMD_SLT: begin
                res = {31'd0, ($signed(a) < $signed(b))};
                carry = wide[DATA_WIDTH];
            end
            CMD_XOR:  res = a ^ b;
            CMD_AND:  res = a & b;
            CMD_NAND: res = ~(a & b);
            CMD_NOR:  res = ~(a | b);
            default:  res = a | b;
        endcase
        zero = (res == 32'd0);
    endtask

    task automatic startOperation(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                                  input logic [DATA_WIDTH-1:0] cmdWord);
        logic [RESP_WIDTH-1:0] resp;
        writeReg(ADDR_OPERAND_A, a, resp);
        checkEqual("bResp operand A", 32'(RESP_OKAY), 32'(resp));
        writeReg(ADDR_OPERAND_B, b, resp);
        checkEqual("bResp operand B", 32'(RESP_OKAY), 32'(resp));
        writeReg(ADDR_COMMAND, cmdWord, resp);
        checkEqual("bResp command", 32'(RESP_OKAY), 32'(resp));
    endtask

    // poll status until busy clears and then compare flags and result with the model
    task automatic checkOperation(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                                  input logic [CMD_WIDTH-1:0] cmd);
        logic [RESP_WIDTH-1:0] resp;
        logic [DATA_WIDTH-1:0] status;
        logic [DATA_WIDTH-1:0] readBack;
        logic [DATA_WIDTH-1:0] expResult;
        logic [DATA_WIDTH-1:0] expStatus;
        logic                  expCarry;
        logic                  expZero;
        logic                  expOverflow;
        modelOperation(a, b, cmd, expResult, expCarry, expZero, expOverflow);
        expStatus = '0;
        expStatus[STATUS_CARRY] = expCarry;
        expStatus[STATUS_ZERO] = expZero;
        expStatus[STATUS_OVERFLOW] = expOverflow;
        do begin
            readReg(ADDR_STATUS, status, resp);
            checkEqual("rResp status", 32'(RESP_OKAY), 32'(resp));
        end while (status[STATUS_BUSY]);
        checkEqual("status", expStatus, status);
        readReg(ADDR_RESULT, readBack, resp);
        checkEqual("result", expResult, readBack);
        checkEqual("rResp result", 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic runOperation(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                                input logic [DATA_WIDTH-1:0] cmdWord);
        startOperation(a, b, cmdWord);
        checkOperation(a, b, cmdWord[CMD_WIDTH-1:0]);
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        #(TOTAL_OPS * CYCLES_PER_OP * CLK_PERIOD_NS);
        $display("timeout: tests still running after %0d cycles", TOTAL_OPS * CYCLES_PER_OP);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [RESP_WIDTH-1:0] resp;
        logic [DATA_WIDTH-1:0] readBack;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] otherWord;
        int                    errorsBefore;

        awValid = 1'b0;
        awAddr = '0;
        wValid = 1'b0;
        wData = '0;
        bReady = 1'b0;
        arValid = 1'b0;
        arAddr = '0;
        rReady = 1'b0;
        seed = 32'hf7c6e4a9;
        errorCount = 0;
        checkCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        maxStall = 0;
        cornerValues = '{32'h7fffffff, 32'h80000000, 32'h00000000, 32'hffffffff};
        cornerCmds = '{CMD_ADD, CMD_SUB, CMD_SLT};
        badWriteAddrs = '{5'h14, 5'h1C, 5'h02, ADDR_RESULT, ADDR_STATUS};
        unmappedAddrs = '{5'h14, 5'h18, 5'h1C, 5'h02};

        wait (arstN === 1'b1);
        @(posedge clk);
        #1;

        errorsBefore = errorCount;
        checkEqual("awReady after reset", 32'd0, 32'(awReady));
        checkEqual("wReady after reset", 32'd0, 32'(wReady));
        checkEqual("bValid after reset", 32'd0, 32'(bValid));
        checkEqual("rValid after reset", 32'd0, 32'(rValid));
        checkEqual("arReady after reset", 32'd1, 32'(arReady));
        readReg(ADDR_STATUS, readBack, resp);
        checkEqual("status after reset", 32'd0, readBack);
        checkEqual("rResp status", 32'(RESP_OKAY), 32'(resp));
        readReg(ADDR_RESULT, readBack, resp);
        checkEqual("result after reset", 32'd0, readBack);
        endTest("reset values", errorsBefore);

        // one in eight draws reuses A as B so that zero results show up
        errorsBefore = errorCount;
        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            a = $random(seed);
            b = $random(seed);
            word = $random(seed);
            if (randomBelow(8) == 0) begin
                b = a;
            end
            runOperation(a, b, word);
        end
        endTest("random operations", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < NUM_CORNER_VALUES; i++) begin
            for (int j = 0; j < NUM_CORNER_VALUES; j++) begin
                for (int k = 0; k < NUM_CORNER_CMDS; k++) begin
                    runOperation(cornerValues[i], cornerValues[j], 32'(cornerCmds[k]));
                end
            end
        end
        endTest("corner operands", errorsBefore);

        // second command lands while the first is still in RUN
        errorsBefore = errorCount;
        for (int i = 0; i < NUM_BUSY_OPS; i++) begin
            a = $random(seed);
            b = $random(seed);
            word = $random(seed);
            otherWord = word + 32'd1;
            startOperation(a, b, word);
            writeReg(ADDR_COMMAND, otherWord, resp);
            checkEqual("bResp command while busy", 32'(RESP_SLVERR), 32'(resp));
            checkOperation(a, b, word[CMD_WIDTH-1:0]);
        end
        endTest("command while busy", errorsBefore);

        errorsBefore = errorCount;
        a = $random(seed);
        b = $random(seed);
        runOperation(a, b, 32'(CMD_ADD));
        for (int i = 0; i < 5; i++) begin
            writeReg(badWriteAddrs[i], $random(seed), resp);
            checkEqual("bResp bad write", 32'(RESP_SLVERR), 32'(resp));
        end
        readReg(ADDR_OPERAND_A, readBack, resp);
        checkEqual("operand A after bad writes", a, readBack);
        readReg(ADDR_OPERAND_B, readBack, resp);
        checkEqual("operand B after bad writes", b, readBack);
        readReg(ADDR_RESULT, readBack, resp);
        checkEqual("result after bad writes", a + b, readBack);
        for (int i = 0; i < 4; i++) begin
            readReg(unmappedAddrs[i], readBack, resp);
            checkEqual("rData unmapped", 32'd0, readBack);
            checkEqual("rResp unmapped", 32'(RESP_SLVERR), 32'(resp));
        end
        endTest("unmapped access", errorsBefore);

        errorsBefore = errorCount;
        maxStall = 5;
        for (int i = 0; i < NUM_STALL_OPS; i++) begin
            a = $random(seed);
            b = $random(seed);
            word = $random(seed);
            runOperation(a, b, word);
        end
        maxStall = 0;
        endTest("response stalls", errorsBefore);

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/aluPkg.sv
source/busPkg.sv
source/aluSlice.sv
source/chunkCounter.sv
source/aluSequencer.sv
source/resultAssembler.sv
source/aluRegs.sv
source/aluTop.sv
tests/clockGen.sv
tests/aluTb.sv

// File: run.sh
#!/bin/sh
# compile and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module aluTb -o aluSim

./obj_dir/aluSim > sim.log
cat sim.log

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
